//--- source/txrst_settings.svh
/* Tx hard reset settings */

`ifndef TXRST_SETTINGS_SVH
`define TXRST_SETTINGS_SVH

//****************************************
// Synchronizer
//****************************************

// Flops per status synchronizer chain
`define TXRST_SYNC_STAGES 3

//****************************************
// Speed change FIFO reset
//****************************************

// Counter wide enough for one delay or pulse phase
`define TXRST_SRST_CNT_W 6
// Cycles of delay and cycles of pulse
`define TXRST_SRST_PULSE_LEN 64

//****************************************
// Bonding master select codes
//****************************************

`define TXRST_MASTER_LOCAL 2'd0
`define TXRST_MASTER_UP 2'd1
// Code 3 falls back to local
`define TXRST_MASTER_DOWN 2'd2

`endif

//--- source/txrst_pkg.sv
/* Tx hard reset types */

`include "txrst_settings.svh"

package txrst_pkg;

	// Bonding master selection
	typedef logic [1:0] master_sel_t;

	// Speed change delay and pulse counter
	typedef logic [`TXRST_SRST_CNT_W-1:0] srst_cnt_t;

	//****************************************
	// Reset sequence states
	//****************************************
	typedef enum logic [2:0]
	{
		// Idle until transfer requested
		wait_tx_transfer_req = 3'b000,
		// DCD calibration requested
		send_tx_dcd_cal_req = 3'b001,
		// Waiting on remote DLL
		wait_remote_tx_dll_lock = 3'b010,
		// Waiting on alignment and FIFO
		wait_remote_tx_align_done = 3'b011,
		// Transfer running
		tx_transfer_en = 3'b100
	} tx_rst_state_t;

endpackage

//--- source/txrst_status_if.sv
/* Synchronized status bundle */

`timescale 1ns/1ns

interface txrst_status_if;

	// ASN DLL lock enable, resets high
	logic dll_lock_en;
	// ASN FIFO hold, starts speed change
	logic fifo_hold;
	// Tx FIFO ready
	logic tx_fifo_ready;
	// Combined DCD calibration done
	logic cal_done;

	// Synchronizer side
	modport sync_src
	(
		output dll_lock_en,
		output fifo_hold,
		output tx_fifo_ready,
		output cal_done
	);

	// Reset state machine side
	modport sm_sink
	(
		input dll_lock_en,
		input tx_fifo_ready,
		input cal_done
	);

	// Speed change pulse side
	modport asn_sink
	(
		input fifo_hold
	);

endinterface

//--- source/txrst_status_sync.sv
/* Status synchronizers */

`timescale 1ns/1ns
`include "txrst_settings.svh"

module txrst_status_sync
(
	input logic tx_clock_hrdrst_rx_osc_clk,
	input logic tx_reset_hrdrst_rx_osc_clk_rst_n,
	input logic rx_asn_dll_lock_en,
	input logic rx_asn_fifo_hold,
	input logic tx_fifo_ready,
	input logic cal_done_comb,
	input logic cal_req_sel,
	output logic aib_cal_req,
	txrst_status_if.sync_src status
);

	//****************************************
	// Chain layout
	//****************************************

	// Bit order: cal_req, cal_done, fifo_ready, fifo_hold, dll_lock_en
	localparam int NUM_SYNC = 5;
	// Only the DLL lock chain comes up high
	localparam logic [NUM_SYNC-1:0] SYNC_RST_VAL = 5'b00001;

	// Raw inputs gathered side by side
	logic [NUM_SYNC-1:0] sync_in;
	// Stage 0 samples the raw inputs
	logic [`TXRST_SYNC_STAGES-1:0][NUM_SYNC-1:0] sync_q;
	// Last stage, stable in this domain
	logic [NUM_SYNC-1:0] sync_out;

	assign sync_in = {cal_req_sel, cal_done_comb, tx_fifo_ready, rx_asn_fifo_hold,
		rx_asn_dll_lock_en};

	//****************************************
	// Shift registers
	//****************************************
	always_ff @(posedge tx_clock_hrdrst_rx_osc_clk)
	begin
		if (!tx_reset_hrdrst_rx_osc_clk_rst_n)
		begin
			sync_q <= {`TXRST_SYNC_STAGES{SYNC_RST_VAL}};
		end
		else
		begin
			// Shift one stage deeper per cycle
			sync_q <= {sync_q[`TXRST_SYNC_STAGES-2:0], sync_in};
		end
	end

	assign sync_out = sync_q[`TXRST_SYNC_STAGES-1];

	// Fan out to consumers
	assign status.dll_lock_en = sync_out[0];
	assign status.fifo_hold = sync_out[1];
	assign status.tx_fifo_ready = sync_out[2];
	assign status.cal_done = sync_out[3];

	// Calibration request retimed before leaving to AIB
	assign aib_cal_req = sync_out[4];

endmodule

//--- source/txrst_speed_chg_srst.sv
/* Speed change FIFO reset */

`timescale 1ns/1ns
`include "txrst_settings.svh"

module txrst_speed_chg_srst
(
	input logic tx_clock_hrdrst_rx_osc_clk,
	input logic tx_reset_hrdrst_rx_osc_clk_rst_n,
	txrst_status_if.asn_sink status,
	output logic speed_chg_srst
);

	import txrst_pkg::*;

	// Final count of each phase, all ones
	localparam srst_cnt_t CNT_LAST = srst_cnt_t'(`TXRST_SRST_PULSE_LEN - 1);

	// Previous FIFO hold for edge detect
	logic fifo_hold_q;
	// Rising edge of FIFO hold
	logic fifo_hold_rise;
	// Delay phase before the pulse
	logic srst_dly;
	// Shared phase counter
	srst_cnt_t srst_cnt;
	logic cnt_done;

	// No restart while a pulse is still out
	assign fifo_hold_rise = status.fifo_hold & ~fifo_hold_q & ~speed_chg_srst;
	assign cnt_done = (srst_cnt == CNT_LAST);

	//****************************************
	// Delay and pulse phases
	//****************************************

	// Pulse long enough for the slowest FIFO clock to sample it
	always_ff @(posedge tx_clock_hrdrst_rx_osc_clk)
	begin
		if (!tx_reset_hrdrst_rx_osc_clk_rst_n)
		begin
			fifo_hold_q <= 1'b0;
			srst_dly <= 1'b0;
			speed_chg_srst <= 1'b0;
			srst_cnt <= '0;
		end
		else
		begin
			fifo_hold_q <= status.fifo_hold;
			// Delay holds until counter wraps
			srst_dly <= fifo_hold_rise | (srst_dly & ~cnt_done);
			// Pulse takes over as delay ends
			speed_chg_srst <= (srst_dly & cnt_done) | (speed_chg_srst & ~cnt_done);
			// Counter runs through both phases, wraps between them
			if (srst_dly || speed_chg_srst)
			begin
				srst_cnt <= srst_cnt + 1'b1;
			end
			else
			begin
				srst_cnt <= '0;
			end
		end
	end

endmodule

//--- source/txrst_reset_sm.sv
/* Tx reset state machine */

`timescale 1ns/1ns

module txrst_reset_sm
(
	input logic tx_clock_hrdrst_rx_osc_clk,
	input logic tx_reset_hrdrst_rx_osc_clk_rst_n,
	input logic avmm_hrdrst_fabric_osc_transfer_en,
	input logic r_tx_hrdrst_rst_sm_dis,
	input logic r_tx_hrdrst_user_ctl_en,
	input logic r_tx_hrdrst_dcd_cal_done_bypass,
	input logic sr_hssi_tx_dcd_cal_done,
	input logic sr_hssi_tx_dll_lock,
	input logic sr_hssi_tx_transfer_en,
	txrst_status_if.sm_sink status,
	output logic cal_req,
	output logic fifo_srst,
	output logic cal_done,
	output logic transfer_en
);

	import txrst_pkg::*;

	tx_rst_state_t state_q;
	tx_rst_state_t state_d;

	// Parked in idle, SM disabled or user in control
	logic sm_hold;

	// Unregistered outputs decoded from state
	logic cal_req_d;
	logic fifo_srst_d;
	logic cal_done_d;
	logic transfer_en_d;

	assign sm_hold = ~avmm_hrdrst_fabric_osc_transfer_en | r_tx_hrdrst_rst_sm_dis
		| r_tx_hrdrst_user_ctl_en;

	//****************************************
	// State register
	//****************************************
	always_ff @(posedge tx_clock_hrdrst_rx_osc_clk)
	begin
		if (!tx_reset_hrdrst_rx_osc_clk_rst_n)
		begin
			state_q <= wait_tx_transfer_req;
		end
		else if (sm_hold)
		begin
			state_q <= wait_tx_transfer_req;
		end
		else
		begin
			state_q <= state_d;
		end
	end

	//****************************************
	// Next state and output decode
	//****************************************
	always_comb
	begin
		state_d = state_q;
		cal_req_d = 1'b0;
		fifo_srst_d = 1'b1;
		cal_done_d = 1'b0;
		transfer_en_d = 1'b0;
		case (state_q)
			wait_tx_transfer_req:
			begin
				// Local cal idle, remote ready for a new request
				if (sr_hssi_tx_dcd_cal_done && status.dll_lock_en && !status.cal_done)
				begin
					state_d = send_tx_dcd_cal_req;
				end
			end
			send_tx_dcd_cal_req:
			begin
				cal_req_d = 1'b1;
				if (status.cal_done || r_tx_hrdrst_dcd_cal_done_bypass)
				begin
					state_d = wait_remote_tx_dll_lock;
				end
			end
			wait_remote_tx_dll_lock:
			begin
				cal_req_d = 1'b1;
				cal_done_d = 1'b1;
				if (sr_hssi_tx_dll_lock)
				begin
					state_d = wait_remote_tx_align_done;
				end
			end
			wait_remote_tx_align_done:
			begin
				cal_req_d = 1'b1;
				// FIFO out of reset for alignment
				fifo_srst_d = 1'b0;
				if (sr_hssi_tx_transfer_en && status.tx_fifo_ready)
				begin
					state_d = tx_transfer_en;
				end
			end
			tx_transfer_en:
			begin
				cal_req_d = 1'b1;
				fifo_srst_d = 1'b0;
				transfer_en_d = 1'b1;
				// Remote drop or DLL relock restarts the sequence
				if (!sr_hssi_tx_transfer_en || !status.dll_lock_en)
				begin
					state_d = wait_tx_transfer_req;
				end
			end
			default:
			begin
				state_d = wait_tx_transfer_req;
			end
		endcase
	end

	//****************************************
	// Registered outputs
	//****************************************
	always_ff @(posedge tx_clock_hrdrst_rx_osc_clk)
	begin
		if (!tx_reset_hrdrst_rx_osc_clk_rst_n)
		begin
			cal_req <= 1'b0;
			// FIFO held in reset from the start
			fifo_srst <= 1'b1;
			cal_done <= 1'b0;
			transfer_en <= 1'b0;
		end
		else
		begin
			cal_req <= cal_req_d;
			fifo_srst <= fifo_srst_d;
			cal_done <= cal_done_d;
			transfer_en <= transfer_en_d;
		end
	end

endmodule

//--- source/txrst_bond_dist.sv
/* Calibration bonding distribution */

`timescale 1ns/1ns
`include "txrst_settings.svh"

module txrst_bond_dist
(
	input logic cal_req,
	input logic aib_fabric_tx_dcd_cal_done,
	input logic pld_aib_fabric_tx_dcd_cal_req,
	input logic usermode_in,
	input logic r_tx_hrdrst_user_ctl_en,
	input logic r_tx_dist_master_sel,
	input logic r_tx_ds_last_chnl,
	input logic r_tx_us_last_chnl,
	input logic r_tx_bonding_dft_in_en,
	input logic r_tx_bonding_dft_in_value,
	input txrst_pkg::master_sel_t r_tx_master_sel,
	input logic bond_tx_hrdrst_ds_in_fabric_tx_dcd_cal_done,
	input logic bond_tx_hrdrst_us_in_fabric_tx_dcd_cal_done,
	input logic bond_tx_hrdrst_ds_in_fabric_tx_dcd_cal_req,
	input logic bond_tx_hrdrst_us_in_fabric_tx_dcd_cal_req,
	output logic bond_tx_hrdrst_ds_out_fabric_tx_dcd_cal_done,
	output logic bond_tx_hrdrst_us_out_fabric_tx_dcd_cal_done,
	output logic bond_tx_hrdrst_ds_out_fabric_tx_dcd_cal_req,
	output logic bond_tx_hrdrst_us_out_fabric_tx_dcd_cal_req,
	output logic cal_req_sel,
	output logic cal_done_comb
);

	// Bond inputs after DFT override
	logic ds_in_done;
	logic us_in_done;
	logic ds_in_req;
	logic us_in_req;
	// Done seen from each side, last channel terminated
	logic done_chnl_down;
	logic done_chnl_up;
	// Fabric request, valid only in user mode
	logic user_cal_req;

	//****************************************
	// DFT override of bonding inputs
	//****************************************
	assign ds_in_done = r_tx_bonding_dft_in_en ? r_tx_bonding_dft_in_value
		: bond_tx_hrdrst_ds_in_fabric_tx_dcd_cal_done;
	assign us_in_done = r_tx_bonding_dft_in_en ? r_tx_bonding_dft_in_value
		: bond_tx_hrdrst_us_in_fabric_tx_dcd_cal_done;
	assign ds_in_req = r_tx_bonding_dft_in_en ? r_tx_bonding_dft_in_value
		: bond_tx_hrdrst_ds_in_fabric_tx_dcd_cal_req;
	assign us_in_req = r_tx_bonding_dft_in_en ? r_tx_bonding_dft_in_value
		: bond_tx_hrdrst_us_in_fabric_tx_dcd_cal_req;

	//****************************************
	// Request distribution
	//****************************************

	// Master drives both ways, others relay through
	assign bond_tx_hrdrst_us_out_fabric_tx_dcd_cal_req = r_tx_dist_master_sel ? cal_req : ds_in_req;
	assign bond_tx_hrdrst_ds_out_fabric_tx_dcd_cal_req = r_tx_dist_master_sel ? cal_req : us_in_req;

	assign user_cal_req = usermode_in & pld_aib_fabric_tx_dcd_cal_req;

	// Request source for this channel
	always_comb
	begin
		if (r_tx_hrdrst_user_ctl_en)
		begin
			cal_req_sel = user_cal_req;
		end
		else
		begin
			case (r_tx_master_sel)
				`TXRST_MASTER_UP: cal_req_sel = us_in_req;
				`TXRST_MASTER_DOWN: cal_req_sel = ds_in_req;
				// Local and spare code
				default: cal_req_sel = cal_req;
			endcase
		end
	end

	//****************************************
	// Done combining
	//****************************************
	assign done_chnl_down = r_tx_ds_last_chnl | ds_in_done;
	assign done_chnl_up = r_tx_us_last_chnl | us_in_done;

	// Whole bonded group done
	assign cal_done_comb = aib_fabric_tx_dcd_cal_done & done_chnl_up & done_chnl_down;

	// Each side passes on what it got from the far side
	assign bond_tx_hrdrst_us_out_fabric_tx_dcd_cal_done = aib_fabric_tx_dcd_cal_done & done_chnl_down;
	assign bond_tx_hrdrst_ds_out_fabric_tx_dcd_cal_done = aib_fabric_tx_dcd_cal_done & done_chnl_up;

endmodule

//--- source/txrst_ctl_top.sv
/* Tx hard reset control top */

`timescale 1ns/1ns
`include "txrst_settings.svh"

module txrst_ctl_top
(
	input logic tx_clock_hrdrst_rx_osc_clk,
	input logic tx_reset_hrdrst_rx_osc_clk_rst_n,
	input logic nfrzdrv_in,
	input logic pr_channel_freeze_n,
	input logic usermode_in,
	input logic pld_aib_fabric_tx_dcd_cal_req,
	input logic pld_fabric_tx_fifo_srst,
	input logic aib_fabric_tx_dcd_cal_done,
	input logic bond_tx_hrdrst_ds_in_fabric_tx_dcd_cal_done,
	input logic bond_tx_hrdrst_us_in_fabric_tx_dcd_cal_done,
	input logic bond_tx_hrdrst_ds_in_fabric_tx_dcd_cal_req,
	input logic bond_tx_hrdrst_us_in_fabric_tx_dcd_cal_req,
	input logic avmm_hrdrst_fabric_osc_transfer_en,
	input logic sr_hssi_tx_dcd_cal_done,
	input logic sr_hssi_tx_dll_lock,
	input logic sr_hssi_tx_transfer_en,
	input logic rx_asn_dll_lock_en,
	input logic rx_asn_fifo_hold,
	input logic tx_fifo_ready,
	input logic r_tx_hrdrst_rst_sm_dis,
	input logic r_tx_hrdrst_dcd_cal_done_bypass,
	input logic r_tx_hrdrst_user_ctl_en,
	input txrst_pkg::master_sel_t r_tx_master_sel,
	input logic r_tx_dist_master_sel,
	input logic r_tx_ds_last_chnl,
	input logic r_tx_us_last_chnl,
	input logic r_tx_bonding_dft_in_en,
	input logic r_tx_bonding_dft_in_value,
	output logic tx_hrdrst_tx_fifo_srst,
	output logic tx_hrdrst_fabric_tx_dcd_cal_done,
	output logic tx_hrdrst_fabric_tx_transfer_en,
	output logic aib_fabric_tx_dcd_cal_req,
	output logic pld_fabric_tx_transfer_en,
	output logic pld_aib_fabric_tx_dcd_cal_done,
	output logic bond_tx_hrdrst_ds_out_fabric_tx_dcd_cal_done,
	output logic bond_tx_hrdrst_us_out_fabric_tx_dcd_cal_done,
	output logic bond_tx_hrdrst_ds_out_fabric_tx_dcd_cal_req,
	output logic bond_tx_hrdrst_us_out_fabric_tx_dcd_cal_req
);

	// Synchronized status bundle
	txrst_status_if status_i ();

	logic sm_cal_req;
	logic sm_fifo_srst;
	logic cal_req_sel;
	logic cal_done_comb;
	logic speed_chg_srst;
	// Freeze active, PLD outputs forced high
	logic frz_force;

	//****************************************
	// Instances
	//****************************************
	txrst_status_sync sync_i
	(
		.tx_clock_hrdrst_rx_osc_clk(tx_clock_hrdrst_rx_osc_clk),
		.tx_reset_hrdrst_rx_osc_clk_rst_n(tx_reset_hrdrst_rx_osc_clk_rst_n),
		.rx_asn_dll_lock_en(rx_asn_dll_lock_en),
		.rx_asn_fifo_hold(rx_asn_fifo_hold),
		.tx_fifo_ready(tx_fifo_ready),
		.cal_done_comb(cal_done_comb),
		.cal_req_sel(cal_req_sel),
		.aib_cal_req(aib_fabric_tx_dcd_cal_req),
		.status(status_i.sync_src)
	);

	txrst_reset_sm sm_i
	(
		.tx_clock_hrdrst_rx_osc_clk(tx_clock_hrdrst_rx_osc_clk),
		.tx_reset_hrdrst_rx_osc_clk_rst_n(tx_reset_hrdrst_rx_osc_clk_rst_n),
		.avmm_hrdrst_fabric_osc_transfer_en(avmm_hrdrst_fabric_osc_transfer_en),
		.r_tx_hrdrst_rst_sm_dis(r_tx_hrdrst_rst_sm_dis),
		.r_tx_hrdrst_user_ctl_en(r_tx_hrdrst_user_ctl_en),
		.r_tx_hrdrst_dcd_cal_done_bypass(r_tx_hrdrst_dcd_cal_done_bypass),
		.sr_hssi_tx_dcd_cal_done(sr_hssi_tx_dcd_cal_done),
		.sr_hssi_tx_dll_lock(sr_hssi_tx_dll_lock),
		.sr_hssi_tx_transfer_en(sr_hssi_tx_transfer_en),
		.status(status_i.sm_sink),
		.cal_req(sm_cal_req),
		.fifo_srst(sm_fifo_srst),
		.cal_done(tx_hrdrst_fabric_tx_dcd_cal_done),
		.transfer_en(tx_hrdrst_fabric_tx_transfer_en)
	);

	txrst_speed_chg_srst speed_chg_i
	(
		.tx_clock_hrdrst_rx_osc_clk(tx_clock_hrdrst_rx_osc_clk),
		.tx_reset_hrdrst_rx_osc_clk_rst_n(tx_reset_hrdrst_rx_osc_clk_rst_n),
		.status(status_i.asn_sink),
		.speed_chg_srst(speed_chg_srst)
	);

	txrst_bond_dist bond_i
	(
		.cal_req(sm_cal_req),
		.aib_fabric_tx_dcd_cal_done(aib_fabric_tx_dcd_cal_done),
		.pld_aib_fabric_tx_dcd_cal_req(pld_aib_fabric_tx_dcd_cal_req),
		.usermode_in(usermode_in),
		.r_tx_hrdrst_user_ctl_en(r_tx_hrdrst_user_ctl_en),
		.r_tx_dist_master_sel(r_tx_dist_master_sel),
		.r_tx_ds_last_chnl(r_tx_ds_last_chnl),
		.r_tx_us_last_chnl(r_tx_us_last_chnl),
		.r_tx_bonding_dft_in_en(r_tx_bonding_dft_in_en),
		.r_tx_bonding_dft_in_value(r_tx_bonding_dft_in_value),
		.r_tx_master_sel(r_tx_master_sel),
		.bond_tx_hrdrst_ds_in_fabric_tx_dcd_cal_done(bond_tx_hrdrst_ds_in_fabric_tx_dcd_cal_done),
		.bond_tx_hrdrst_us_in_fabric_tx_dcd_cal_done(bond_tx_hrdrst_us_in_fabric_tx_dcd_cal_done),
		.bond_tx_hrdrst_ds_in_fabric_tx_dcd_cal_req(bond_tx_hrdrst_ds_in_fabric_tx_dcd_cal_req),
		.bond_tx_hrdrst_us_in_fabric_tx_dcd_cal_req(bond_tx_hrdrst_us_in_fabric_tx_dcd_cal_req),
		.bond_tx_hrdrst_ds_out_fabric_tx_dcd_cal_done(bond_tx_hrdrst_ds_out_fabric_tx_dcd_cal_done),
		.bond_tx_hrdrst_us_out_fabric_tx_dcd_cal_done(bond_tx_hrdrst_us_out_fabric_tx_dcd_cal_done),
		.bond_tx_hrdrst_ds_out_fabric_tx_dcd_cal_req(bond_tx_hrdrst_ds_out_fabric_tx_dcd_cal_req),
		.bond_tx_hrdrst_us_out_fabric_tx_dcd_cal_req(bond_tx_hrdrst_us_out_fabric_tx_dcd_cal_req),
		.cal_req_sel(cal_req_sel),
		.cal_done_comb(cal_done_comb)
	);

	//****************************************
	// Freeze forcing
	//****************************************
	assign frz_force = ~(nfrzdrv_in & pr_channel_freeze_n);
	assign pld_fabric_tx_transfer_en = frz_force | tx_hrdrst_fabric_tx_transfer_en;
	assign pld_aib_fabric_tx_dcd_cal_done = frz_force | aib_fabric_tx_dcd_cal_done;

	//****************************************
	// FIFO reset source
	//****************************************

	// Master uses its own SM, slaves follow the ASN speed change
	// Spare code counts as local
	assign tx_hrdrst_tx_fifo_srst = r_tx_hrdrst_user_ctl_en ? pld_fabric_tx_fifo_srst
		: (r_tx_master_sel == `TXRST_MASTER_UP || r_tx_master_sel == `TXRST_MASTER_DOWN)
		? speed_chg_srst : sm_fifo_srst;

endmodule

//--- testbench/txrst_clk_gen.sv
/* Testbench clock and reset */

`timescale 1ns/1ns

module txrst_clk_gen
(
	output logic tx_clock_hrdrst_rx_osc_clk,
	output logic tx_reset_hrdrst_rx_osc_clk_rst_n
);

	// 100 ns period
	localparam int HALF_PERIOD = 50;
	// Rising edges seen with reset low
	localparam int RESET_CYCLES = 2;

	initial
	begin
		tx_clock_hrdrst_rx_osc_clk = 1'b0;
		forever
		begin
			#HALF_PERIOD tx_clock_hrdrst_rx_osc_clk = ~tx_clock_hrdrst_rx_osc_clk;
		end
	end

	// Release just after an edge, like the other inputs
	initial
	begin
		tx_reset_hrdrst_rx_osc_clk_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge tx_clock_hrdrst_rx_osc_clk);
		#10 tx_reset_hrdrst_rx_osc_clk_rst_n = 1'b1;
	end

endmodule

//--- testbench/txrst_checker.sv
/* Reset SM and pulse assertions */

`timescale 1ns/1ns

module txrst_checker
(
	input logic tx_clock_hrdrst_rx_osc_clk,
	input logic tx_reset_hrdrst_rx_osc_clk_rst_n,
	input logic [2:0] state,
	input logic transfer_en,
	input logic fifo_srst,
	input logic srst_dly,
	input logic speed_chg_srst
);

	import txrst_pkg::*;

	// Assertion failures so far
	int fail_cnt = 0;

	//****************************************
	// Reset state machine
	//****************************************

	// Only the five encodings of the enum
	state_legal: assert property (@(posedge tx_clock_hrdrst_rx_osc_clk)
		disable iff (!tx_reset_hrdrst_rx_osc_clk_rst_n)
		state inside {wait_tx_transfer_req, send_tx_dcd_cal_req, wait_remote_tx_dll_lock,
			wait_remote_tx_align_done, tx_transfer_en})
	else
	begin
		$error("reset SM state %b is not a legal encoding", state);
		fail_cnt++;
	end

	// FIFO out of reset whenever transfer runs
	xfer_no_srst: assert property (@(posedge tx_clock_hrdrst_rx_osc_clk)
		disable iff (!tx_reset_hrdrst_rx_osc_clk_rst_n)
		transfer_en |-> !fifo_srst)
	else
	begin
		$error("transfer enable is high while the FIFO reset is high");
		fail_cnt++;
	end

	//****************************************
	// Speed change pulse
	//****************************************
	pulse_after_dly: assert property (@(posedge tx_clock_hrdrst_rx_osc_clk)
		disable iff (!tx_reset_hrdrst_rx_osc_clk_rst_n)
		!(srst_dly && speed_chg_srst))
	else
	begin
		$error("speed change pulse overlaps its delay phase");
		fail_cnt++;
	end

endmodule

// Pulse inputs tied idle on the SM side
bind txrst_reset_sm txrst_checker sm_chk_i
(
	.tx_clock_hrdrst_rx_osc_clk(tx_clock_hrdrst_rx_osc_clk),
	.tx_reset_hrdrst_rx_osc_clk_rst_n(tx_reset_hrdrst_rx_osc_clk_rst_n),
	.state(state_q),
	.transfer_en(transfer_en),
	.fifo_srst(fifo_srst),
	.srst_dly(1'b0),
	.speed_chg_srst(1'b0)
);

// SM inputs tied to idle values on the pulse side
bind txrst_speed_chg_srst txrst_checker srst_chk_i
(
	.tx_clock_hrdrst_rx_osc_clk(tx_clock_hrdrst_rx_osc_clk),
	.tx_reset_hrdrst_rx_osc_clk_rst_n(tx_reset_hrdrst_rx_osc_clk_rst_n),
	.state(3'b000),
	.transfer_en(1'b0),
	.fifo_srst(1'b1),
	.srst_dly(srst_dly),
	.speed_chg_srst(speed_chg_srst)
);

//--- testbench/txrst_tb.sv
/* Tx hard reset testbench */

`timescale 1ns/1ns

module txrst_tb;

	import txrst_pkg::*;

	// Cycle limits, one per kind of wait
	localparam int ROW_TIMEOUT = 40;
	localparam int PULSE_TIMEOUT = 200;
	localparam int RESET_TIMEOUT = 8;
	// Drive offset after the rising edge
	localparam int DRIVE_DELAY = 10;

	logic tx_clock_hrdrst_rx_osc_clk;
	logic tx_reset_hrdrst_rx_osc_clk_rst_n;
	logic nfrzdrv_in;
	logic pr_channel_freeze_n;
	logic usermode_in;
	logic pld_aib_fabric_tx_dcd_cal_req;
	logic pld_fabric_tx_fifo_srst;
	logic aib_fabric_tx_dcd_cal_done;
	logic bond_tx_hrdrst_ds_in_fabric_tx_dcd_cal_done;
	logic bond_tx_hrdrst_us_in_fabric_tx_dcd_cal_done;
	logic bond_tx_hrdrst_ds_in_fabric_tx_dcd_cal_req;
	logic bond_tx_hrdrst_us_in_fabric_tx_dcd_cal_req;
	logic avmm_hrdrst_fabric_osc_transfer_en;
	logic sr_hssi_tx_dcd_cal_done;
	logic sr_hssi_tx_dll_lock;
	logic sr_hssi_tx_transfer_en;
	logic rx_asn_dll_lock_en;
	logic rx_asn_fifo_hold;
	logic tx_fifo_ready;
	logic r_tx_hrdrst_rst_sm_dis;
	logic r_tx_hrdrst_dcd_cal_done_bypass;
	logic r_tx_hrdrst_user_ctl_en;
	master_sel_t r_tx_master_sel;
	logic r_tx_dist_master_sel;
	logic r_tx_ds_last_chnl;
	logic r_tx_us_last_chnl;
	logic r_tx_bonding_dft_in_en;
	logic r_tx_bonding_dft_in_value;
	logic tx_hrdrst_tx_fifo_srst;
	logic tx_hrdrst_fabric_tx_dcd_cal_done;
	logic tx_hrdrst_fabric_tx_transfer_en;
	logic aib_fabric_tx_dcd_cal_req;
	logic pld_fabric_tx_transfer_en;
	logic pld_aib_fabric_tx_dcd_cal_done;
	logic bond_tx_hrdrst_ds_out_fabric_tx_dcd_cal_done;
	logic bond_tx_hrdrst_us_out_fabric_tx_dcd_cal_done;
	logic bond_tx_hrdrst_ds_out_fabric_tx_dcd_cal_req;
	logic bond_tx_hrdrst_us_out_fabric_tx_dcd_cal_req;

	// Idle gap generator state
	logic [31:0] rand_state;

	txrst_clk_gen clk_gen_i
	(
		.tx_clock_hrdrst_rx_osc_clk(tx_clock_hrdrst_rx_osc_clk),
		.tx_reset_hrdrst_rx_osc_clk_rst_n(tx_reset_hrdrst_rx_osc_clk_rst_n)
	);

	txrst_ctl_top dut_i (.*);

	//****************************************
	// Helpers
	//****************************************
	function automatic logic [31:0] xorshift32(input logic [31:0] seed);
		logic [31:0] x;
		x = seed;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic fail_stop(input string reason);
		$display("%0s", reason);
		$display("tests failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic compare_level(input string test_name, input string sig_name,
		input logic exp_val, input logic act_val);
		if (act_val !== exp_val)
		begin
			fail_stop($sformatf("error: test %0s, %0s expected %b actual %b",
				test_name, sig_name, exp_val, act_val));
		end
	endtask

	task automatic compare_bond(input string test_name, input logic [3:0] exp_val,
		input logic [3:0] act_val);
		if (act_val !== exp_val)
		begin
			fail_stop($sformatf("error: test %0s, bond outputs expected %b actual %b",
				test_name, exp_val, act_val));
		end
	endtask

	task automatic compare_count(input string test_name, input int exp_val, input int act_val);
		if (act_val != exp_val)
		begin
			fail_stop($sformatf("error: test %0s, pulse cycles expected %0d actual %0d",
				test_name, exp_val, act_val));
		end
	endtask

	// Order matches the exp_lvl column of the trace
	function automatic logic [5:0] level_outputs();
		return {tx_hrdrst_tx_fifo_srst, tx_hrdrst_fabric_tx_dcd_cal_done,
			tx_hrdrst_fabric_tx_transfer_en, aib_fabric_tx_dcd_cal_req,
			pld_fabric_tx_transfer_en, pld_aib_fabric_tx_dcd_cal_done};
	endfunction

	function automatic logic [3:0] bond_outputs();
		return {bond_tx_hrdrst_ds_out_fabric_tx_dcd_cal_done,
			bond_tx_hrdrst_us_out_fabric_tx_dcd_cal_done,
			bond_tx_hrdrst_ds_out_fabric_tx_dcd_cal_req,
			bond_tx_hrdrst_us_out_fabric_tx_dcd_cal_req};
	endfunction

	task automatic drive_inputs(input logic [1:0] frz, input logic [2:0] pld,
		input logic [4:0] bond_in, input logic [3:0] hssi, input logic [2:0] asn,
		input logic [2:0] csr, input master_sel_t msel, input logic [4:0] bcfg);
		{nfrzdrv_in, pr_channel_freeze_n} = frz;
		{usermode_in, pld_aib_fabric_tx_dcd_cal_req, pld_fabric_tx_fifo_srst} = pld;
		{aib_fabric_tx_dcd_cal_done, bond_tx_hrdrst_ds_in_fabric_tx_dcd_cal_done,
			bond_tx_hrdrst_us_in_fabric_tx_dcd_cal_done,
			bond_tx_hrdrst_ds_in_fabric_tx_dcd_cal_req,
			bond_tx_hrdrst_us_in_fabric_tx_dcd_cal_req} = bond_in;
		{avmm_hrdrst_fabric_osc_transfer_en, sr_hssi_tx_dcd_cal_done, sr_hssi_tx_dll_lock,
			sr_hssi_tx_transfer_en} = hssi;
		{rx_asn_dll_lock_en, rx_asn_fifo_hold, tx_fifo_ready} = asn;
		{r_tx_hrdrst_rst_sm_dis, r_tx_hrdrst_dcd_cal_done_bypass, r_tx_hrdrst_user_ctl_en} = csr;
		r_tx_master_sel = msel;
		{r_tx_dist_master_sel, r_tx_ds_last_chnl, r_tx_us_last_chnl, r_tx_bonding_dft_in_en,
			r_tx_bonding_dft_in_value} = bcfg;
	endtask

	//****************************************
	// Pulse length and row checks
	//****************************************

	// Counts falling edges that see the FIFO reset high
	task automatic measure_pulse(input string test_name, input int exp_len);
		int wait_cycles;
		int high_cycles;
		wait_cycles = 0;
		while (tx_hrdrst_tx_fifo_srst !== 1'b1 && wait_cycles < PULSE_TIMEOUT)
		begin
			@(negedge tx_clock_hrdrst_rx_osc_clk);
			wait_cycles++;
		end
		if (tx_hrdrst_tx_fifo_srst !== 1'b1)
		begin
			fail_stop($sformatf("test %0s: FIFO reset pulse never started", test_name));
		end
		high_cycles = 0;
		while (tx_hrdrst_tx_fifo_srst === 1'b1 && high_cycles < PULSE_TIMEOUT)
		begin
			high_cycles++;
			@(negedge tx_clock_hrdrst_rx_osc_clk);
		end
		compare_count(test_name, exp_len, high_cycles);
	endtask

	task automatic run_row(input string test_name, input logic [1:0] frz,
		input logic [2:0] pld, input logic [4:0] bond_in, input logic [3:0] hssi,
		input logic [2:0] asn, input logic [2:0] csr, input master_sel_t msel,
		input logic [4:0] bcfg, input logic [5:0] exp_lvl, input logic [3:0] exp_bond,
		input int exp_pulse);
		int cycles;
		logic matched;
		@(posedge tx_clock_hrdrst_rx_osc_clk);
		#DRIVE_DELAY;
		drive_inputs(frz, pld, bond_in, hssi, asn, csr, msel, bcfg);
		if (exp_pulse != 0)
		begin
			measure_pulse(test_name, exp_pulse);
		end
		// Outputs settle over a sync chain and a few SM steps
		cycles = 0;
		matched = 1'b0;
		while (!matched && cycles < ROW_TIMEOUT)
		begin
			@(negedge tx_clock_hrdrst_rx_osc_clk);
			matched = (level_outputs() === exp_lvl) && (bond_outputs() === exp_bond);
			cycles++;
		end
		if (!matched)
		begin
			compare_level(test_name, "tx_hrdrst_tx_fifo_srst", exp_lvl[5],
				tx_hrdrst_tx_fifo_srst);
			compare_level(test_name, "tx_hrdrst_fabric_tx_dcd_cal_done", exp_lvl[4],
				tx_hrdrst_fabric_tx_dcd_cal_done);
			compare_level(test_name, "tx_hrdrst_fabric_tx_transfer_en", exp_lvl[3],
				tx_hrdrst_fabric_tx_transfer_en);
			compare_level(test_name, "aib_fabric_tx_dcd_cal_req", exp_lvl[2],
				aib_fabric_tx_dcd_cal_req);
			compare_level(test_name, "pld_fabric_tx_transfer_en", exp_lvl[1],
				pld_fabric_tx_transfer_en);
			compare_level(test_name, "pld_aib_fabric_tx_dcd_cal_done", exp_lvl[0],
				pld_aib_fabric_tx_dcd_cal_done);
			compare_bond(test_name, exp_bond, bond_outputs());
		end
	endtask

	//****************************************
	// Trace replay
	//****************************************
	initial
	begin
		int fd;
		int n;
		int rows;
		int wait_cycles;
		int assert_fails;
		int exp_pulse;
		logic [8*256-1:0] line_buf;
		logic [8*32-1:0] name_buf;
		logic [1:0] frz;
		logic [2:0] pld;
		logic [4:0] bond_in;
		logic [3:0] hssi;
		logic [2:0] asn;
		logic [2:0] csr;
		master_sel_t msel;
		logic [4:0] bcfg;
		logic [5:0] exp_lvl;
		logic [3:0] exp_bond;
		// No freeze, local master, end of a bond chain
		drive_inputs(2'b11, 3'b100, 5'b00000, 4'b0000, 3'b100, 3'b000, 2'b00, 5'b11100);
		rand_state = 32'd36;
		wait_cycles = 0;
		while (tx_reset_hrdrst_rx_osc_clk_rst_n !== 1'b1 && wait_cycles < RESET_TIMEOUT)
		begin
			@(posedge tx_clock_hrdrst_rx_osc_clk);
			wait_cycles++;
		end
		if (tx_reset_hrdrst_rx_osc_clk_rst_n !== 1'b1)
		begin
			fail_stop("reset was never released");
		end
		fd = $fopen("testbench/txrst_trace.txt", "r");
		if (fd == 0)
		begin
			fail_stop("trace file testbench/txrst_trace.txt could not be opened");
		end
		rows = 0;
		while (!$feof(fd))
		begin
			line_buf = '0;
			n = $fgets(line_buf, fd);
			n = $sscanf(line_buf, "%s %b %b %b %b %b %b %b %b %b %b %d", name_buf, frz, pld,
				bond_in, hssi, asn, csr, msel, bcfg, exp_lvl, exp_bond, exp_pulse);
			// Comment and blank lines stop short of a full row
			if (n == 12)
			begin
				run_row($sformatf("%0s", name_buf), frz, pld, bond_in, hssi, asn, csr, msel,
					bcfg, exp_lvl, exp_bond, exp_pulse);
				rows++;
				rand_state = xorshift32(rand_state);
				repeat (rand_state % 4) @(posedge tx_clock_hrdrst_rx_osc_clk);
			end
		end
		$fclose(fd);
		assert_fails = dut_i.sm_i.sm_chk_i.fail_cnt + dut_i.speed_chg_i.srst_chk_i.fail_cnt;
		if (rows == 0)
		begin
			fail_stop("no rows were read from the trace file");
		end
		else if (assert_fails != 0)
		begin
			fail_stop($sformatf("%0d checker assertions failed", assert_fails));
		end
		else
		begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

//--- compile.f
+incdir+source
source/txrst_pkg.sv
source/txrst_status_if.sv
source/txrst_status_sync.sv
source/txrst_speed_chg_srst.sv
source/txrst_reset_sm.sv
source/txrst_bond_dist.sv
source/txrst_ctl_top.sv
testbench/txrst_clk_gen.sv
testbench/txrst_checker.sv
testbench/txrst_tb.sv

//--- testbench/txrst_trace.txt
# Row: name frz pld bond_in hssi asn csr msel bcfg exp_lvl exp_bond pulse
# frz = nfrzdrv_in pr_channel_freeze_n
# pld = usermode_in pld_aib_fabric_tx_dcd_cal_req pld_fabric_tx_fifo_srst
# bond_in = aib_fabric_tx_dcd_cal_done ds_in_done us_in_done ds_in_req us_in_req
# hssi = avmm_hrdrst_fabric_osc_transfer_en sr_hssi_tx_dcd_cal_done sr_hssi_tx_dll_lock
#   sr_hssi_tx_transfer_en
# asn = rx_asn_dll_lock_en rx_asn_fifo_hold tx_fifo_ready
# csr = r_tx_hrdrst_rst_sm_dis r_tx_hrdrst_dcd_cal_done_bypass r_tx_hrdrst_user_ctl_en
# msel = r_tx_master_sel
# bcfg = r_tx_dist_master_sel ds_last us_last dft_in_en dft_in_value
# exp_lvl = tx_fifo_srst fabric_cal_done fabric_transfer_en aib_cal_req
#   pld_transfer_en pld_cal_done
# exp_bond = ds_out_done us_out_done ds_out_req us_out_req
# pulse = expected FIFO reset pulse length in cycles, 0 for none
reset_state         11 100 00000 0000 100 000 00 11100 100000 0000 0
bringup_cal_req     11 100 00000 1100 100 000 00 11100 100100 0011 0
bringup_cal_done    11 100 10000 1100 100 000 00 11100 110101 1111 0
bringup_dll_lock    11 100 10000 1110 100 000 00 11100 000101 1111 0
bringup_xfer_en     11 100 10000 1111 101 000 00 11100 001111 1111 0
bringup_xfer_drop   11 100 10000 1110 101 000 00 11100 100001 1100 0
freeze_nfrzdrv      01 100 10000 1110 101 000 00 11100 100011 1100 0
freeze_pr_channel   10 100 10000 1110 101 000 00 11100 100011 1100 0
freeze_off_recal    11 100 00000 1110 101 000 00 11100 100100 0011 0
sm_disable          11 100 00000 1110 101 100 00 11100 100000 0000 0
user_ctl_fifo_srst  11 100 00000 1110 101 001 00 11100 000000 0000 0
user_ctl_cal_req    11 110 00000 1110 101 001 00 11100 000100 0000 0
user_ctl_no_umode   11 011 00000 1110 101 001 00 11100 100000 0000 0
bond_ds_not_last    11 100 10000 0000 100 000 00 10100 100001 1000 0
bond_ds_in_done     11 100 11000 0000 100 000 00 10100 100001 1100 0
bond_us_not_last    11 100 10000 0000 100 000 00 11000 100001 0100 0
bond_relay          11 100 10001 0000 100 000 00 00000 100001 0010 0
bond_master_up      11 100 10001 0000 100 000 01 00000 000101 0010 0
bond_master_down    11 100 10001 0000 100 000 10 00000 000001 0010 0
bond_dft_one        11 100 10001 0000 100 000 10 00011 000101 1111 0
bond_dft_zero       11 100 10001 0000 100 000 10 00010 000001 0000 0
speed_chg_idle      11 100 00000 0000 100 000 01 11100 000000 0000 0
speed_chg_pulse     11 100 00000 0000 110 000 01 11100 000000 0000 64
